// File: flist.f
+incdir+.
emgc_pkg.sv
emgc_if.sv
emgc_cfg_regs.sv
reply_timeout_ctrl.sv
recovery_delay.sv
chan_emgc_ctrl.sv
ccw_emgc_ctrl.sv
emergency_ctrl.sv
emgc_checker.sv
emgc_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = emgc_tb
RTL_TOP    = emergency_ctrl
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: emgc_tb.sv
`timescale 1ns/1ps
`include "emgc_defs.svh"

module emgc_tb;

	localparam int IDLE_TIMEOUT = 200;

	// Clock cycles in the 100 us recovery delay, counted from zero
	localparam int DEFAULT_TICKS = (`EMGC_CLK_FREQ / 1000000) * 100 - 1;

	logic                clk = 1'b0;
	logic                n_rst;
	logic                ccw_accepted;
	logic [2:0]          window;
	logic                rx_sd_busy;
	logic                rx_start_bit_accepted;
	logic                rx_frame_end;
	logic                rx_err;
	logic                cfg_wr;
	emgc_pkg::cfg_addr_e cfg_addr;
	logic [15:0]         cfg_wdata;
	logic [15:0]         cfg_rdata;
	logic [2:0]          repeat_reqs;
	logic                switch_com_src_req;
	logic                rst_com_src_ctrl;
	logic [2:0]          ev_fault;
	logic                ev_busy;
	logic [15:0]         exp_ticks;
	logic [2:0]          exp_limit;
	logic                model_busy;
	int                  tests = 0;
	int                  failed = 0;
	int                  err_start;

	always #5 clk = ~clk;

	emergency_ctrl i_emergency_ctrl
	(
		.clk                         (clk),
		.n_rst                       (n_rst),
		.ccw_accepted                (ccw_accepted),
		.delays_after_cmds_for_reply (window),
		.rx_sd_busy                  (rx_sd_busy),
		.rx_start_bit_accepted       (rx_start_bit_accepted),
		.rx_frame_end                (rx_frame_end),
		.rx_err                      (rx_err),
		.cfg_wr                      (cfg_wr),
		.cfg_addr                    (cfg_addr),
		.cfg_wdata                   (cfg_wdata),
		.cfg_rdata                   (cfg_rdata),
		.repeat_reqs                 (repeat_reqs),
		.switch_com_src_req          (switch_com_src_req),
		.rst_com_src_ctrl            (rst_com_src_ctrl)
	);

	emgc_checker i_emgc_checker
	(
		.clk                (clk),
		.n_rst              (n_rst),
		.ev_fault           (ev_fault),
		.ev_busy            (ev_busy),
		.ccw_accepted       (ccw_accepted),
		.exp_ticks          (exp_ticks),
		.exp_limit          (exp_limit),
		.repeat_reqs        (repeat_reqs),
		.switch_com_src_req (switch_com_src_req),
		.rst_com_src_ctrl   (rst_com_src_ctrl),
		.model_busy         (model_busy)
	);

	// ********************
	// Stimulus tasks
	// ********************

	task automatic write_cfg(input emgc_pkg::cfg_addr_e addr, input logic [15:0] data);
		@(posedge clk);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_wr <= 1'b0;
	endtask

	task automatic read_cfg(input emgc_pkg::cfg_addr_e addr, input logic [15:0] exp_val);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		i_emgc_checker.check_value(exp_val, cfg_rdata);
	endtask

	// Window closes without any start bit
	task automatic window_timeout(input int c);
		@(posedge clk);
		window[c] <= 1'b1;
		repeat (3) @(posedge clk);
		window[c] <= 1'b0;
		ev_fault  <= 3'(1 << c);
		@(posedge clk);
		ev_fault <= '0;
	endtask

	task automatic reply_frame(input int c, input logic err, input logic busy);
		@(posedge clk);
		window[c] <= 1'b1;
		@(posedge clk);
		rx_start_bit_accepted <= 1'b1;
		@(posedge clk);
		rx_start_bit_accepted <= 1'b0;
		repeat (2) @(posedge clk);
		rx_frame_end <= 1'b1;
		rx_err       <= err;
		rx_sd_busy   <= busy;
		ev_fault     <= err ? 3'(1 << c) : 3'b000;
		ev_busy      <= (c == 2) && busy && !err;
		@(posedge clk);
		rx_frame_end <= 1'b0;
		rx_err       <= 1'b0;
		rx_sd_busy   <= 1'b0;
		ev_fault     <= '0;
		ev_busy      <= 1'b0;
		@(posedge clk);
		window[c] <= 1'b0;
	endtask

	task automatic pulse_accept();
		@(posedge clk);
		ccw_accepted <= 1'b1;
		@(posedge clk);
		ccw_accepted <= 1'b0;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_idle(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (model_busy && (n < IDLE_TIMEOUT))
		begin
			@(negedge clk);
			n = n + 1;
		end
		if (model_busy)
			stop_on_timeout(what);
	endtask

	task automatic begin_test(input string name);
		i_emgc_checker.test_name = name;
		err_start = i_emgc_checker.errors;
	endtask

	task automatic end_test();
		tests = tests + 1;
		if (i_emgc_checker.errors != err_start)
		begin
			failed = failed + 1;
			$display("test %s: failed", i_emgc_checker.test_name);
		end
		else
			$display("test %s: ok", i_emgc_checker.test_name);
	endtask

	// ********************
	// Test sequence
	// ********************

	initial
	begin
		void'($urandom(32'ha800_b845));
		n_rst = 1'b0;
		ccw_accepted = 1'b0;
		window = '0;
		rx_sd_busy = 1'b0;
		rx_start_bit_accepted = 1'b0;
		rx_frame_end = 1'b0;
		rx_err = 1'b0;
		cfg_wr = 1'b0;
		cfg_addr = emgc_pkg::CFG_DELAY_TICKS;
		cfg_wdata = '0;
		ev_fault = '0;
		ev_busy = 1'b0;
		exp_ticks = 16'(DEFAULT_TICKS);
		exp_limit = 3'(`EMGC_CCW_LIMIT_RST);
		repeat (2) @(posedge clk);
		n_rst <= 1'b1;

		begin_test("reset_and_regs");
		read_cfg(emgc_pkg::CFG_DELAY_TICKS, 16'(DEFAULT_TICKS));
		read_cfg(emgc_pkg::CFG_CCW_LIMIT, 16'(`EMGC_CCW_LIMIT_RST));
		exp_ticks = 16'(8 + ($urandom % 33));
		exp_limit = 3'd2;
		write_cfg(emgc_pkg::CFG_DELAY_TICKS, exp_ticks);
		write_cfg(emgc_pkg::CFG_CCW_LIMIT, 16'(exp_limit));
		read_cfg(emgc_pkg::CFG_DELAY_TICKS, exp_ticks);
		read_cfg(emgc_pkg::CFG_CCW_LIMIT, 16'(exp_limit));
		end_test();

		begin_test("sr_timeout");
		for (int i = 0; i < 2; i++)
		begin
			window_timeout(0);
			wait_idle("SR recovery");
		end
		end_test();

		begin_test("dpr_frame_error");
		reply_frame(1, 1'b1, 1'b0);
		wait_idle("DPR recovery");
		reply_frame(1, 1'b0, 1'b0);
		wait_idle("DPR good frame");
		reply_frame(1, 1'b1, 1'b0);
		wait_idle("DPR reset");
		end_test();

		begin_test("ccw_retries");
		for (int i = 0; i < 4; i++)
		begin
			window_timeout(2);
			wait_idle("CCW recovery");
		end
		pulse_accept();
		for (int i = 0; i < 2; i++)
		begin
			window_timeout(2);
			wait_idle("CCW recovery after accept");
		end
		end_test();

		begin_test("ccw_busy_reply");
		reply_frame(2, 1'b0, 1'b1);
		wait_idle("CCW busy reply");
		end_test();

		// DPR fault first, SR timeout a few cycles later in the same delay
		begin_test("overlap");
		reply_frame(1, 1'b1, 1'b0);
		window_timeout(0);
		wait_idle("overlapping recovery");
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests, failed, i_emgc_checker.errors);
		if ((failed == 0) && (i_emgc_checker.errors == 0))
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		#200us;
		$display("Run did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: emgc_checker.sv
`timescale 1ns/1ps

module emgc_checker
(
	input  logic        clk,
	input  logic        n_rst,
	input  logic [2:0]  ev_fault,
	input  logic        ev_busy,
	input  logic        ccw_accepted,
	input  logic [15:0] exp_ticks,
	input  logic [2:0]  exp_limit,
	input  logic [2:0]  repeat_reqs,
	input  logic        switch_com_src_req,
	input  logic        rst_com_src_ctrl,
	output logic        model_busy
);

	int    errors = 0;
	string test_name = "reset";

	// ********************
	// Reference model state
	// ********************

	logic       run;
	logic [2:0] pend;
	logic [1:0] repeated;
	logic       rst_next;
	int         ccw_cnt;
	int         cyc;
	int         deadline;

	assign model_busy = run | rst_next;

	// Returns {repeat, switch, reset next cycle} for one channel
	function logic [2:0] ref_response(input int c, input logic fd, input logic busy);
		logic [2:0] r;
		r = 3'b000;
		if (c == 2)
		begin
			if (fd)
			begin
				if (ccw_cnt < int'(exp_limit))
				begin
					r = 3'b110;
					ccw_cnt = ccw_cnt + 1;
				end
				else
				begin
					r = 3'b001;
					ccw_cnt = 0;
				end
			end
			else if (ccw_accepted)
				ccw_cnt = 0;
			if (busy)
				r[2] = 1'b1;
		end
		else if (fd)
		begin
			r = repeated[c] ? 3'b001 : 3'b110;
			repeated[c] = ~repeated[c];
		end
		return r;
	endfunction

	task check_value(input logic [15:0] exp_val, input logic [15:0] act_val);
		if (exp_val !== act_val)
		begin
			$display("FAIL %s: expected %0d, actual %0d", test_name, exp_val, act_val);
			errors = errors + 1;
		end
	endtask

	always @(posedge clk or negedge n_rst)
	begin : compare
		logic       done;
		logic [2:0] fd;
		logic [2:0] r;
		logic [2:0] rep;
		logic       sw;
		logic       rn;
		logic [4:0] exp_out;
		logic [4:0] act_out;
		if (!n_rst)
		begin
			run      = 1'b0;
			pend     = '0;
			repeated = '0;
			rst_next = 1'b0;
			ccw_cnt  = 0;
			cyc      = 0;
			deadline = 0;
		end
		else
		begin
			done = run && (cyc == deadline);
			fd   = done ? pend : 3'b000;
			rep  = '0;
			sw   = 1'b0;
			rn   = 1'b0;
			for (int c = 0; c < 3; c++)
			begin
				r      = ref_response(c, fd[c], ev_busy && (c == 2));
				rep[c] = r[2];
				sw     = sw | r[1];
				rn     = rn | r[0];
			end
			exp_out = {rep, sw, rst_next};
			act_out = {repeat_reqs, switch_com_src_req, rst_com_src_ctrl};
			if (exp_out !== act_out)
			begin
				$display("FAIL %s: expected %05b, actual %05b (cycle %0d)",
					test_name, exp_out, act_out, cyc);
				errors = errors + 1;
			end
			rst_next = rn;
			// Shared delay, the first fault sets the deadline
			if ((ev_fault != 3'b000) && (done || !run))
			begin
				run      = 1'b1;
				pend     = ev_fault;
				deadline = cyc + int'(exp_ticks) + 1;
			end
			else if (ev_fault != 3'b000)
				pend = pend | ev_fault;
			else if (done)
			begin
				run  = 1'b0;
				pend = '0;
			end
			cyc = cyc + 1;
		end
	end

endmodule

// File: emergency_ctrl.sv
`timescale 1ns/1ps
`include "emgc_defs.svh"

module emergency_ctrl
(
	input  logic                clk,
	input  logic                n_rst,
	input  logic                ccw_accepted,
	input  logic [2:0]          delays_after_cmds_for_reply,
	input  logic                rx_sd_busy,
	input  logic                rx_start_bit_accepted,
	input  logic                rx_frame_end,
	input  logic                rx_err,
	input  logic                cfg_wr,
	input  emgc_pkg::cfg_addr_e cfg_addr,
	input  logic [15:0]         cfg_wdata,
	output logic [15:0]         cfg_rdata,
	output logic [2:0]          repeat_reqs,
	output logic                switch_com_src_req,
	output logic                rst_com_src_ctrl
);

	logic [`EMGC_DELAY_W-1:0] delay_ticks;
	logic [`EMGC_CNT_W-1:0]   ccw_limit;
	logic [2:0]               chan_switch;
	logic [2:0]               chan_rst;

	emgc_if i_emgc_if();

	// ********************
	// Fault detection and delay
	// ********************

	reply_timeout_ctrl i_reply_timeout_ctrl
	(
		.clk                         (clk),
		.n_rst                       (n_rst),
		.delays_after_cmds_for_reply (delays_after_cmds_for_reply),
		.rx_start_bit_accepted       (rx_start_bit_accepted),
		.rx_frame_end                (rx_frame_end),
		.rx_err                      (rx_err),
		.rx_sd_busy                  (rx_sd_busy),
		.det                         (i_emgc_if.detect)
	);

	recovery_delay i_recovery_delay
	(
		.clk         (clk),
		.n_rst       (n_rst),
		.delay_ticks (delay_ticks),
		.dly         (i_emgc_if.delay)
	);

	emgc_cfg_regs i_emgc_cfg_regs
	(
		.clk         (clk),
		.n_rst       (n_rst),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.delay_ticks (delay_ticks),
		.ccw_limit   (ccw_limit)
	);

	// ********************
	// Channel controllers
	// ********************

	chan_emgc_ctrl i_sr_emgc_ctrl
	(
		.clk                (clk),
		.n_rst              (n_rst),
		.fault_done         (i_emgc_if.fault_done[emgc_pkg::CMD_SR]),
		.repeat_req         (repeat_reqs[emgc_pkg::CMD_SR]),
		.switch_com_src_req (chan_switch[emgc_pkg::CMD_SR]),
		.rst_com_src_ctrl   (chan_rst[emgc_pkg::CMD_SR])
	);

	chan_emgc_ctrl i_dpr_emgc_ctrl
	(
		.clk                (clk),
		.n_rst              (n_rst),
		.fault_done         (i_emgc_if.fault_done[emgc_pkg::CMD_DPR]),
		.repeat_req         (repeat_reqs[emgc_pkg::CMD_DPR]),
		.switch_com_src_req (chan_switch[emgc_pkg::CMD_DPR]),
		.rst_com_src_ctrl   (chan_rst[emgc_pkg::CMD_DPR])
	);

	ccw_emgc_ctrl i_ccw_emgc_ctrl
	(
		.clk                (clk),
		.n_rst              (n_rst),
		.ccw_accepted       (ccw_accepted),
		.ccw_limit          (ccw_limit),
		.ch                 (i_emgc_if.chan),
		.repeat_req         (repeat_reqs[emgc_pkg::CMD_CCW]),
		.switch_com_src_req (chan_switch[emgc_pkg::CMD_CCW]),
		.rst_com_src_ctrl   (chan_rst[emgc_pkg::CMD_CCW])
	);

	// One shared request line each towards the source switch
	assign switch_com_src_req = |chan_switch;
	assign rst_com_src_ctrl   = |chan_rst;

endmodule

// File: ccw_emgc_ctrl.sv
`timescale 1ns/1ps
`include "emgc_defs.svh"

module ccw_emgc_ctrl
(
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   ccw_accepted,
	input  logic [`EMGC_CNT_W-1:0] ccw_limit,
	emgc_if.chan                   ch,
	output logic                   repeat_req,
	output logic                   switch_com_src_req,
	output logic                   rst_com_src_ctrl
);

	logic [`EMGC_CNT_W-1:0] cnt;
	logic                   ccw_done;
	logic                   below;
	logic                   retry;

	assign ccw_done = ch.fault_done[emgc_pkg::CMD_CCW];
	assign below    = (cnt < ccw_limit);
	assign retry    = ccw_done & below;

	// ********************
	// Retry counter
	// ********************

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			cnt <= '0;
		else if (ccw_done)
		begin
			if (below)
				cnt <= cnt + 1'b1;
			else
				cnt <= '0;
		end
		else if (ccw_accepted)
			cnt <= '0;
	end

	// ********************
	// Requests
	// ********************

	// Busy reply repeats on the same source
	assign repeat_req         = retry | ch.ccw_busy_reply;
	assign switch_com_src_req = retry;

	// Retry budget spent, reset the source controller
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			rst_com_src_ctrl <= 1'b0;
		else
			rst_com_src_ctrl <= ccw_done & ~below;
	end

endmodule

// File: chan_emgc_ctrl.sv
`timescale 1ns/1ps

module chan_emgc_ctrl
(
	input  logic clk,
	input  logic n_rst,
	input  logic fault_done,
	output logic repeat_req,
	output logic switch_com_src_req,
	output logic rst_com_src_ctrl
);

	emgc_pkg::chan_state_e state;
	logic                  is_idle;

	assign is_idle = (state == emgc_pkg::ST_IDLE);

	// ********************
	// Recovery state
	// ********************

	// First fault repeats on the other source, second one resets
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			state <= emgc_pkg::ST_IDLE;
		else if (fault_done)
		begin
			if (is_idle)
				state <= emgc_pkg::ST_REPEATED;
			else
				state <= emgc_pkg::ST_IDLE;
		end
	end

	assign repeat_req         = fault_done & is_idle;
	assign switch_com_src_req = fault_done & is_idle;

	// Source reset follows one cycle after the second fault
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			rst_com_src_ctrl <= 1'b0;
		else
			rst_com_src_ctrl <= fault_done & ~is_idle;
	end

endmodule

// File: recovery_delay.sv
`timescale 1ns/1ps
`include "emgc_defs.svh"

module recovery_delay
(
	input  logic                     clk,
	input  logic                     n_rst,
	input  logic [`EMGC_DELAY_W-1:0] delay_ticks,
	emgc_if.delay                    dly
);

	logic                     run;
	logic [`EMGC_DELAY_W-1:0] cnt;
	logic [2:0]               pend;
	logic                     done;
	logic                     any_start;

	assign any_start = |dly.fault_start;

	// Counter starts at zero the cycle after the first fault
	assign done = run & (cnt >= delay_ticks);

	assign dly.fault_done = pend & {3{done}};

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			run  <= 1'b0;
			cnt  <= '0;
			pend <= '0;
		end
		else if (done)
		begin
			// A fault in the last cycle opens a fresh delay
			run  <= any_start;
			cnt  <= '0;
			pend <= dly.fault_start;
		end
		else if (run)
		begin
			cnt  <= cnt + 1'b1;
			pend <= pend | dly.fault_start;
		end
		else if (any_start)
		begin
			run  <= 1'b1;
			cnt  <= '0;
			pend <= dly.fault_start;
		end
	end

endmodule

// File: reply_timeout_ctrl.sv
`timescale 1ns/1ps

module reply_timeout_ctrl
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [2:0] delays_after_cmds_for_reply,
	input  logic       rx_start_bit_accepted,
	input  logic       rx_frame_end,
	input  logic       rx_err,
	input  logic       rx_sd_busy,
	emgc_if.detect     det
);

	logic [2:0] win_q;
	logic [2:0] win_fall;
	logic       any_fall;
	logic [2:0] reply_seen;
	logic [2:0] recv;
	logic       frame_end_q;
	logic       start_in_win;

	// ********************
	// Window edges
	// ********************

	assign win_fall     = win_q & ~delays_after_cmds_for_reply;
	assign any_fall     = |win_fall;
	assign start_in_win = rx_start_bit_accepted & (|delays_after_cmds_for_reply);

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			win_q       <= '0;
			frame_end_q <= 1'b0;
		end
		else
		begin
			win_q       <= delays_after_cmds_for_reply;
			frame_end_q <= rx_frame_end;
		end
	end

	// A start bit marks the reply as seen for every open window
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			reply_seen <= '0;
		else
			reply_seen <= (any_fall ? 3'b000 : reply_seen)
				| (delays_after_cmds_for_reply & {3{rx_start_bit_accepted}});
	end

	// Reception marker, dropped one cycle after the frame end
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			recv <= '0;
		else if (frame_end_q)
			recv <= '0;
		else if (start_in_win)
			recv <= delays_after_cmds_for_reply;
	end

	// ********************
	// Fault pulses
	// ********************

	assign det.timeout        = win_fall & ~reply_seen;
	assign det.frame_fault    = recv & {3{rx_frame_end & rx_err}};
	assign det.fault_start    = det.timeout | det.frame_fault;
	assign det.ccw_busy_reply = recv[emgc_pkg::CMD_CCW] & rx_frame_end
		& rx_sd_busy & ~rx_err;

endmodule

// File: emgc_cfg_regs.sv
`timescale 1ns/1ps
`include "emgc_defs.svh"

module emgc_cfg_regs
(
	input  logic                     clk,
	input  logic                     n_rst,
	input  logic                     cfg_wr,
	input  emgc_pkg::cfg_addr_e      cfg_addr,
	input  logic [15:0]              cfg_wdata,
	output logic [15:0]              cfg_rdata,
	output logic [`EMGC_DELAY_W-1:0] delay_ticks,
	output logic [`EMGC_CNT_W-1:0]   ccw_limit
);

	// ********************
	// Register writes
	// ********************

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			delay_ticks <= `EMGC_DELAY_W'(`EMGC_DELAY_TICKS_RST);
			ccw_limit   <= `EMGC_CNT_W'(`EMGC_CCW_LIMIT_RST);
		end
		else if (cfg_wr)
		begin
			if (cfg_addr == emgc_pkg::CFG_DELAY_TICKS)
				delay_ticks <= cfg_wdata[`EMGC_DELAY_W-1:0];
			else
				ccw_limit <= cfg_wdata[`EMGC_CNT_W-1:0];
		end
	end

	// Read mux, upper bits zero
	always_comb
	begin
		cfg_rdata = '0;
		case (cfg_addr)
			emgc_pkg::CFG_DELAY_TICKS: cfg_rdata[`EMGC_DELAY_W-1:0] = delay_ticks;
			emgc_pkg::CFG_CCW_LIMIT:   cfg_rdata[`EMGC_CNT_W-1:0]   = ccw_limit;
		endcase
	end

endmodule

// File: emgc_if.sv
`timescale 1ns/1ps

interface emgc_if;

	// Per-channel fault pulses from the detector
	logic [2:0] timeout;
	logic [2:0] frame_fault;
	logic [2:0] fault_start;
	logic       ccw_busy_reply;

	// End of recovery, one bit per pending channel
	logic [2:0] fault_done;

	modport detect
	(
		output timeout,
		output frame_fault,
		output fault_start,
		output ccw_busy_reply
	);

	modport delay
	(
		input  fault_start,
		output fault_done
	);

	modport chan
	(
		input fault_done,
		input ccw_busy_reply
	);

endinterface

// File: emgc_pkg.sv
package emgc_pkg;

	// ********************
	// Command channels
	// ********************

	// Bit positions in every 3-bit channel vector
	typedef enum logic [1:0]
	{
		CMD_SR  = 2'd0,
		CMD_DPR = 2'd1,
		CMD_CCW = 2'd2
	} cmd_e;

	// SR and DPR recovery state
	typedef enum logic
	{
		ST_IDLE     = 1'b0,
		ST_REPEATED = 1'b1
	} chan_state_e;

	// Configuration register select
	typedef enum logic
	{
		CFG_DELAY_TICKS = 1'b0,
		CFG_CCW_LIMIT   = 1'b1
	} cfg_addr_e;

endpackage

// File: emgc_defs.svh
`ifndef EMGC_DEFS_SVH
`define EMGC_DEFS_SVH

// ********************
// Clock and timing
// ********************

`define EMGC_CLK_FREQ 50000000

// Ticks in 100 us, counted from zero
`define EMGC_DELAY_TICKS_RST ((`EMGC_CLK_FREQ / 10000) - 1)
`define EMGC_DELAY_W 16

// ********************
// CCW retries
// ********************

`define EMGC_CCW_LIMIT_RST 3
`define EMGC_CNT_W 3

`endif
